/* common/smc_settings.svh */
// Bus widths, register map and timing field widths
// for the static memory controller
`ifndef SMC_SETTINGS_SVH
`define SMC_SETTINGS_SVH

// Bus widths
`define SMC_ADDR_W  32  // AHB and EMI address
`define SMC_DATA_W  32  // AHB, APB and EMI data
`define SMC_BE_W    4   // One enable per byte lane
`define SMC_PADDR_W 5

// APB register map
`define SMC_REG_TIMING 5'h00

// Timing field widths
`define SMC_WS_W   8  // Wait states
`define SMC_EDGE_W 2  // Chip-select lead and trail

// Lead 1, wait states 2, trail 1
`define SMC_TIMING_RESET 32'h0001_0201

`endif

/* common/smc_pkg.sv */
// Shared types: timing register view, transfer size, AHB response,
// EMI engine state
`default_nettype none

package smc_pkg;

`include "smc_settings.svh"

  // Encoding follows hsize[1:0]
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } smc_size_e;

  typedef enum logic [1:0] {
    OKAY  = 2'b00,
    ERROR = 2'b01
  } smc_resp_e;

  // Engine states
  typedef enum logic [1:0] {
    IDLE,
    LEAD,    // CS low, strobe not yet
    STROBE,  // CS and strobe low
    TRAIL    // Bus turnaround
  } smc_state_e;

  typedef struct packed {
    logic [13:0]            spare_hi;     // 31:18, always zero
    logic [`SMC_EDGE_W-1:0] cs_trail;     // 17:16
    logic [`SMC_WS_W-1:0]   wait_states;  // 15:8
    logic [5:0]             spare_lo;     // 7:2, always zero
    logic [`SMC_EDGE_W-1:0] cs_lead;      // 1:0
  } smc_timing_t;

  // Same word as seen by APB and by the engine
  typedef union packed {
    logic [`SMC_DATA_W-1:0] raw;
    smc_timing_t            f;
  } smc_timing_u;

endpackage

`default_nettype wire

/* common/smc_cmd_if.sv */
// One-deep command channel from the AHB slave to the EMI engine
`timescale 1ns/10ps
`default_nettype none

`include "smc_settings.svh"

interface smc_cmd_if (
  input wire logic hclk
);

  // Request side, one-cycle pulse on valid
  logic                   valid;
  logic                   write;    // 1 write, 0 read
  logic [`SMC_ADDR_W-1:0] addr;
  logic [`SMC_BE_W-1:0]   n_be;     // Active low
  logic [`SMC_DATA_W-1:0] wdata;

  // Engine side
  logic                   ready;    // Engine idle
  logic                   done;     // Last strobe cycle
  logic [`SMC_DATA_W-1:0] rdata;    // Valid with done

  modport requester (
    input  hclk, ready, done, rdata,
    output valid, write, addr, n_be, wdata
  );

  modport server (
    input  hclk, valid, write, addr, n_be, wdata,
    output ready, done, rdata
  );

endinterface

`default_nettype wire

/* rtl/smc_config_regs.sv */
// APB timing register with readback
`timescale 1ns/10ps
`default_nettype none

`include "smc_settings.svh"

module smc_config_regs
  import smc_pkg::*;
(
  input  wire logic                    hclk,
  input  wire logic                    rst_n,
  input  wire logic                    psel,
  input  wire logic                    penable,
  input  wire logic                    pwrite,
  input  wire logic [`SMC_PADDR_W-1:0] paddr,
  input  wire logic [`SMC_DATA_W-1:0]  pwdata,
  output logic [`SMC_DATA_W-1:0]       prdata,
  output smc_timing_u                  timing
);

  logic        reg_hit;   // Offset decode
  logic        wr_en;
  logic        rd_en;
  smc_timing_u wr_view;   // pwdata seen as fields
  smc_timing_u wr_word;   // Spare bits cleared

  assign reg_hit = (paddr == `SMC_REG_TIMING);
  assign wr_en   = psel & penable & pwrite & reg_hit;   // Access phase only
  assign rd_en   = psel & penable & ~pwrite & reg_hit;

  assign wr_view.raw = pwdata;

  // Keep only the defined fields
  always_comb begin
    wr_word               = '0;
    wr_word.f.cs_lead     = wr_view.f.cs_lead;
    wr_word.f.wait_states = wr_view.f.wait_states;
    wr_word.f.cs_trail    = wr_view.f.cs_trail;
  end

  //--------------------------------------------------------------------
  // Timing register
  //--------------------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      timing.raw <= `SMC_TIMING_RESET;
    end else if (wr_en) begin
      timing <= wr_word;
    end
  end

  // Other offsets read zero
  assign prdata = rd_en ? timing.raw : '0;

endmodule

`default_nettype wire

/* rtl/smc_ahb_slave.sv */
// AHB-Lite slave: address capture, alignment check, byte enables,
// wait and error responses, command issue to the EMI engine
`timescale 1ns/10ps
`default_nettype none

`include "smc_settings.svh"

module smc_ahb_slave
  import smc_pkg::*;
(
  input  wire logic                   hclk,
  input  wire logic                   rst_n,
  input  wire logic [`SMC_ADDR_W-1:0] haddr,
  input  wire logic [1:0]             htrans,
  input  wire logic                   hsel,
  input  wire logic                   hwrite,
  input  wire logic [2:0]             hsize,
  input  wire logic [`SMC_DATA_W-1:0] hwdata,
  input  wire logic                   hready,
  output logic [`SMC_DATA_W-1:0]      smc_hrdata,
  output logic                        smc_hready,
  output smc_resp_e                   smc_hresp,
  smc_cmd_if.requester                cmd
);

  smc_size_e              size;
  logic                   capture;     // Address phase accepted
  logic                   bad_xfer;    // Misaligned or unsupported size
  logic [`SMC_BE_W-1:0]   n_be_dec;

  // Data phase tracking
  logic                   pend;        // Legal access waiting for engine
  logic                   issued;      // Handed over, waiting for done
  logic                   err_1;       // First ERROR cycle
  logic                   err_2;       // Second ERROR cycle

  // Captured address phase
  logic                   a_write;
  logic [`SMC_ADDR_W-1:0] a_addr;
  logic [`SMC_BE_W-1:0]   a_n_be;

  assign size    = smc_size_e'(hsize[1:0]);
  assign capture = hsel & htrans[1] & hready;   // NONSEQ or SEQ, bus not held

  //--------------------------------------------------------------------
  // Size and alignment decode
  //--------------------------------------------------------------------
  always_comb begin
    n_be_dec = '1;
    bad_xfer = 1'b0;
    case (size)
      SIZE_BYTE: n_be_dec = ~(4'b0001 << haddr[1:0]);
      SIZE_HALF: begin
        n_be_dec = ~(4'b0011 << {haddr[1], 1'b0});
        bad_xfer = haddr[0];                  // Odd halfword
      end
      SIZE_WORD: begin
        n_be_dec = '0;
        bad_xfer = |haddr[1:0];
      end
      default:   bad_xfer = 1'b1;            // Doubleword
    endcase
    if (hsize[2]) begin
      bad_xfer = 1'b1;                       // Wider than the bus
    end
  end

  //--------------------------------------------------------------------
  // Data phase control
  //--------------------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      pend   <= 1'b0;
      issued <= 1'b0;
      err_1  <= 1'b0;
      err_2  <= 1'b0;
    end else begin
      err_1 <= capture & bad_xfer;
      err_2 <= err_1;
      if (capture && !bad_xfer) begin
        pend <= 1'b1;
      end else if (cmd.valid) begin
        pend <= 1'b0;
      end
      if (cmd.valid) begin
        issued <= 1'b1;
      end else if (cmd.done) begin
        issued <= 1'b0;
      end
    end
  end

  always_ff @(posedge hclk) begin
    if (capture) begin
      a_write <= hwrite;
      a_addr  <= haddr;
      a_n_be  <= n_be_dec;
    end
  end

  // Issue once the engine is idle, write data straight from the data phase
  assign cmd.valid = pend & cmd.ready;
  assign cmd.write = a_write;
  assign cmd.addr  = a_addr;
  assign cmd.n_be  = a_n_be;
  assign cmd.wdata = hwdata;

  // Low through the data phase, released by done or second ERROR cycle
  assign smc_hready = ~(pend | issued | err_1) | (issued & cmd.done);
  assign smc_hresp  = (err_1 | err_2) ? ERROR : OKAY;
  assign smc_hrdata = cmd.rdata;

endmodule

`default_nettype wire

/* emi/smc_emi_engine.sv */
// EMI access engine: state machine, lead/trail and wait-state counters,
// registered chip select, strobes, address and write data
`timescale 1ns/10ps
`default_nettype none

`include "smc_settings.svh"

module smc_emi_engine
  import smc_pkg::*;
(
  input  wire logic                   hclk,
  input  wire logic                   rst_n,
  input  wire smc_timing_u            timing,
  smc_cmd_if.server                   cmd,
  input  wire logic [`SMC_DATA_W-1:0] data_smc,
  output logic [`SMC_ADDR_W-1:0]      smc_addr,
  output logic [`SMC_DATA_W-1:0]      smc_data,
  output logic [`SMC_BE_W-1:0]        smc_n_be,
  output logic                        smc_n_cs,
  output logic [`SMC_BE_W-1:0]        smc_n_we,
  output logic                        smc_n_wr,
  output logic                        smc_n_rd,
  output logic                        smc_n_ext_oe,
  output logic                        smc_busy
);

  smc_state_e             state;
  logic [`SMC_EDGE_W-1:0] edge_cnt;    // Lead, then trail
  logic [`SMC_WS_W-1:0]   ws_cnt;      // Strobe cycles left minus one
  logic [`SMC_EDGE_W-1:0] trail_q;     // Trail taken at acceptance
  logic                   wr_q;        // Access direction

  logic                   accept;
  logic                   strobe_go;   // Strobe falls on next edge
  logic                   strobe_end;  // Last strobe cycle
  logic                   acc_write;
  logic [`SMC_BE_W-1:0]   acc_n_be;

  assign accept     = cmd.valid & cmd.ready;
  assign strobe_end = (state == STROBE) && (ws_cnt == '0);
  assign strobe_go  = (accept && (timing.f.cs_lead == '0)) ||
                      ((state == LEAD) && (edge_cnt == '0));

  // Direction and lanes straight from the command when lead is zero
  assign acc_write = accept ? cmd.write : wr_q;
  assign acc_n_be  = accept ? cmd.n_be  : smc_n_be;

  //--------------------------------------------------------------------
  // State machine and control outputs
  //--------------------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      state        <= IDLE;
      edge_cnt     <= '0;
      ws_cnt       <= '0;
      trail_q      <= '0;
      wr_q         <= 1'b0;
      smc_n_cs     <= 1'b1;
      smc_n_be     <= '1;
      smc_n_rd     <= 1'b1;
      smc_n_wr     <= 1'b1;
      smc_n_we     <= '1;
      smc_n_ext_oe <= 1'b1;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            state        <= (timing.f.cs_lead == '0) ? STROBE : LEAD;
            edge_cnt     <= timing.f.cs_lead - 1'b1;   // Don't care if lead is 0
            ws_cnt       <= timing.f.wait_states;
            trail_q      <= timing.f.cs_trail;
            wr_q         <= cmd.write;
            smc_n_cs     <= 1'b0;
            smc_n_be     <= cmd.n_be;
            smc_n_ext_oe <= ~cmd.write;                // Drive bus on writes
          end
        end
        LEAD: begin
          if (edge_cnt == '0) begin
            state <= STROBE;
          end else begin
            edge_cnt <= edge_cnt - 1'b1;
          end
        end
        STROBE: begin
          if (strobe_end) begin
            state        <= (trail_q == '0) ? IDLE : TRAIL;
            edge_cnt     <= trail_q - 1'b1;
            smc_n_cs     <= 1'b1;
            smc_n_be     <= '1;
            smc_n_ext_oe <= 1'b1;
          end else begin
            ws_cnt <= ws_cnt - 1'b1;
          end
        end
        TRAIL: begin
          if (edge_cnt == '0) begin
            state <= IDLE;
          end else begin
            edge_cnt <= edge_cnt - 1'b1;
          end
        end
        default: state <= IDLE;
      endcase

      // Strobes cover the whole wait-state phase
      if (strobe_go) begin
        smc_n_rd <= acc_write;
        smc_n_wr <= ~acc_write;
        smc_n_we <= acc_write ? acc_n_be : '1;   // Lane strobes follow n_be
      end else if (strobe_end) begin
        smc_n_rd <= 1'b1;
        smc_n_wr <= 1'b1;
        smc_n_we <= '1;
      end
    end
  end

  //--------------------------------------------------------------------
  // Address and write data
  //--------------------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (accept) begin
      smc_addr <= cmd.addr;
      smc_data <= cmd.wdata;
    end
  end

  assign cmd.ready = (state == IDLE);   // Low through trail too
  assign cmd.done  = strobe_end;
  assign cmd.rdata = strobe_end ? data_smc : '0;   // Device drives during strobe
  assign smc_busy  = (state != IDLE);

endmodule

`default_nettype wire

/* rtl/smc_top.sv */
// Static memory controller top: AHB slave, APB timing register, EMI engine
`timescale 1ns/10ps
`default_nettype none

`include "smc_settings.svh"

module smc_top
  import smc_pkg::*;
(
  input  wire logic                    hclk,
  input  wire logic                    rst_n,
  // APB
  input  wire logic                    psel,
  input  wire logic                    penable,
  input  wire logic                    pwrite,
  input  wire logic [`SMC_PADDR_W-1:0] paddr,
  input  wire logic [`SMC_DATA_W-1:0]  pwdata,
  output logic [`SMC_DATA_W-1:0]       prdata,
  // AHB
  input  wire logic [`SMC_ADDR_W-1:0]  haddr,
  input  wire logic [1:0]              htrans,
  input  wire logic                    hsel,
  input  wire logic                    hwrite,
  input  wire logic [2:0]              hsize,
  input  wire logic [`SMC_DATA_W-1:0]  hwdata,
  input  wire logic                    hready,
  output logic [`SMC_DATA_W-1:0]       smc_hrdata,
  output logic                         smc_hready,
  output logic [1:0]                   smc_hresp,
  // EMI
  output logic [`SMC_ADDR_W-1:0]       smc_addr,
  output logic [`SMC_DATA_W-1:0]       smc_data,
  input  wire logic [`SMC_DATA_W-1:0]  data_smc,
  output logic [`SMC_BE_W-1:0]         smc_n_be,
  output logic                         smc_n_cs,
  output logic [`SMC_BE_W-1:0]         smc_n_we,
  output logic                         smc_n_wr,
  output logic                         smc_n_rd,
  output logic                         smc_n_ext_oe,
  output logic                         smc_busy
);

  smc_timing_u timing;   // Register to engine
  smc_resp_e   hresp;

  smc_cmd_if cmd_if (.hclk(hclk));

  smc_config_regs u_regs (
    .hclk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
    .timing (timing)
  );

  smc_ahb_slave u_ahb (
    .hclk, .rst_n, .haddr, .htrans, .hsel, .hwrite, .hsize, .hwdata, .hready,
    .smc_hrdata, .smc_hready,
    .smc_hresp (hresp),
    .cmd       (cmd_if.requester)
  );

  smc_emi_engine u_emi (
    .hclk, .rst_n,
    .timing (timing),
    .cmd    (cmd_if.server),
    .data_smc, .smc_addr, .smc_data, .smc_n_be, .smc_n_cs, .smc_n_we,
    .smc_n_wr, .smc_n_rd, .smc_n_ext_oe, .smc_busy
  );

  assign smc_hresp = hresp;   // Plain 2-bit response at the pins

endmodule

`default_nettype wire

/* bench/smc_props.sv */
// EMI strobe, chip-select and busy rules, bound into the EMI engine
`timescale 1ns/10ps
`default_nettype none

`include "smc_settings.svh"

module smc_props (
  input wire logic                 hclk,
  input wire logic                 rst_n,
  input wire logic                 smc_n_cs,
  input wire logic                 smc_n_rd,
  input wire logic                 smc_n_wr,
  input wire logic [`SMC_BE_W-1:0] smc_n_we,
  input wire logic                 smc_n_ext_oe,
  input wire logic                 smc_busy
);

  //----------------------------------------------------------------------
  // Strobe rules
  //----------------------------------------------------------------------
  // Read strobe only with the bus released and write strobe only with it driven
  rd_wr_exclusive: assert property (@(posedge hclk) disable iff (!rst_n)
    (smc_n_rd || smc_n_ext_oe) && (smc_n_wr || !smc_n_ext_oe))
    else $error("strobe direction does not match the data bus drive");

  // Any strobe needs the device selected
  strobe_in_cs: assert property (@(posedge hclk) disable iff (!rst_n)
    (!smc_n_rd || !smc_n_wr || (smc_n_we != '1)) |-> !smc_n_cs)
    else $error("strobe low while chip select is high");

  // Idle engine has released chip select and the data bus
  busy_idle: assert property (@(posedge hclk) disable iff (!rst_n)
    !smc_busy |-> (smc_n_cs && smc_n_ext_oe))
    else $error("chip select or bus drive active while not busy");

endmodule

`default_nettype wire

/* bench/smc_tb.sv */
// Testbench for the static memory controller: random APB and AHB traffic,
// SRAM model, strobe timing and turnaround checks
`timescale 1ns/10ps
`default_nettype none

`include "smc_settings.svh"

module smc_tb
  import smc_pkg::*;
();

  localparam int TIMEOUT = 2000;   // Cycles per wait

  logic        hclk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [4:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic [31:0] haddr;
  logic [1:0]  htrans;
  logic        hsel;
  logic        hwrite;
  logic [2:0]  hsize;
  logic [31:0] hwdata;
  logic        hready;
  logic [31:0] smc_hrdata;
  logic        smc_hready;
  logic [1:0]  smc_hresp;
  logic [31:0] smc_addr;
  logic [31:0] smc_data;
  logic [31:0] data_smc;
  logic [3:0]  smc_n_be;
  logic        smc_n_cs;
  logic [3:0]  smc_n_we;
  logic        smc_n_wr;
  logic        smc_n_rd;
  logic        smc_n_ext_oe;
  logic        smc_busy;

  int          errors;
  int          checks;
  int          timeouts;
  int          hi_run;       // Consecutive cycles with CS high
  int          prev_trail;
  smc_timing_u tb_timing;    // Model of the timing register
  logic [7:0]  mem [256];    // SRAM device
  logic [7:0]  ref_mem [256];

  smc_top DUT (.*);

  bind smc_emi_engine smc_props u_props (
    .hclk(hclk), .rst_n(rst_n), .smc_n_cs(smc_n_cs), .smc_n_rd(smc_n_rd),
    .smc_n_wr(smc_n_wr), .smc_n_we(smc_n_we), .smc_n_ext_oe(smc_n_ext_oe),
    .smc_busy(smc_busy)
  );

  initial hclk = 1'b0;
  always #50 hclk = ~hclk;

  //----------------------------------------------------------------------
  // SRAM model, asynchronous read
  //----------------------------------------------------------------------
  assign data_smc = smc_n_rd ? 32'h0 :
    {mem[{smc_addr[7:2], 2'd3}], mem[{smc_addr[7:2], 2'd2}],
     mem[{smc_addr[7:2], 2'd1}], mem[{smc_addr[7:2], 2'd0}]};

  always @(posedge hclk) begin
    for (int i = 0; i < 4; i++) begin
      if (!smc_n_we[i]) mem[{smc_addr[7:2], 2'(i)}] <= smc_data[8*i +: 8];
    end
  end

  always @(negedge hclk) hi_run <= (!rst_n || !smc_n_cs) ? 0 : hi_run + 1;

  //----------------------------------------------------------------------
  // Compare tasks
  //----------------------------------------------------------------------
  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input smc_resp_e got, input smc_resp_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0t %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic check_timing(input string name, input smc_timing_u got,
                              input smc_timing_u exp);
    checks++;
    if (got.raw !== exp.raw) begin
      errors++;
      $display("Fail %0t %s got %h expected %h", $time, name, got.raw, exp.raw);
    end
  endtask

  // at_least set for minimum counts
  task automatic check_count(input string name, input int got, input int exp,
                             input bit at_least);
    checks++;
    if (at_least ? (got < exp) : (got != exp)) begin
      errors++;
      $display("Fail %0t %s got %0d expected %s%0d", $time, name, got,
               at_least ? "at least " : "", exp);
    end
  endtask

  //----------------------------------------------------------------------
  // Bus tasks
  //----------------------------------------------------------------------
  task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
    @(negedge hclk);
    psel   = 1'b1;
    pwrite = 1'b1;
    paddr  = addr;
    pwdata = data;
    @(negedge hclk);
    penable = 1'b1;
    @(negedge hclk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input logic [4:0] addr, output logic [31:0] data);
    @(negedge hclk);
    psel   = 1'b1;
    pwrite = 1'b0;
    paddr  = addr;
    @(negedge hclk);
    penable = 1'b1;
    @(posedge hclk);
    data = prdata;               // Access phase
    @(negedge hclk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // One AHB transfer, samples EMI pins each data-phase cycle
  task automatic ahb_access(input logic wr, input logic [31:0] addr, input logic [2:0] size,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output smc_resp_e resp, output smc_resp_e first_resp,
                            output logic first_rdy, output int cycles, output int cs_cyc,
                            output int stb_cyc, output int gap, output logic [3:0] n_we_seen,
                            output logic [3:0] n_be_seen, output logic [31:0] addr_seen,
                            output int oe_cyc);
    bit fin;
    fin = 1'b0;
    cycles = 0;
    cs_cyc = 0;
    stb_cyc = 0;
    gap = 0;
    n_we_seen = '1;
    n_be_seen = '1;
    addr_seen = '0;
    oe_cyc = 0;
    first_rdy = 1'b0;
    first_resp = OKAY;
    rdata = '0;
    resp = OKAY;
    @(negedge hclk);
    hsel   = 1'b1;
    htrans = 2'b10;              // NONSEQ
    haddr  = addr;
    hwrite = wr;
    hsize  = size;
    @(negedge hclk);
    hsel   = 1'b0;
    htrans = 2'b00;
    hwdata = wdata;
    while (!fin) begin
      cycles++;
      if (cycles == 1) begin
        first_rdy  = smc_hready;
        first_resp = smc_resp_e'(smc_hresp);
      end
      if (!smc_n_cs) begin
        if (cs_cyc == 0) gap = hi_run;
        cs_cyc++;
        n_be_seen = n_be_seen & smc_n_be;   // Any lane seen active
        addr_seen = smc_addr;
      end
      if (!smc_n_ext_oe) oe_cyc++;
      if (!smc_n_rd || !smc_n_wr) stb_cyc++;
      if (!smc_n_wr) n_we_seen = smc_n_we;
      if (smc_hready) begin
        rdata = smc_hrdata;
        resp  = smc_resp_e'(smc_hresp);
        fin   = 1'b1;
      end else if (cycles > TIMEOUT) begin
        $display("Timeout at %0t waiting for smc_hready", $time);
        timeouts++;
        fin = 1'b1;
      end else begin
        @(negedge hclk);
      end
    end
  endtask

  // Lane i is active when it falls inside the transfer's byte range
  function automatic logic [3:0] lane_enables(input logic [31:0] a, input logic [2:0] size);
    int         nbytes;
    int         first;
    logic [3:0] n_be;
    nbytes = 1 << size;
    first  = int'(a[1:0]) & ~(nbytes - 1);
    for (int i = 0; i < 4; i++) begin
      n_be[i] = !((i >= first) && (i < first + nbytes));
    end
    return n_be;
  endfunction

  task automatic legal_access(input logic wr, input logic [31:0] addr, input logic [2:0] size);
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [31:0] exp;
    logic [3:0]  n_be;
    logic [3:0]  n_we_seen;
    logic [3:0]  n_be_seen;
    logic [31:0] addr_seen;
    smc_resp_e   resp;
    smc_resp_e   first_resp;
    logic        first_rdy;
    int          cycles;
    int          cs_cyc;
    int          stb_cyc;
    int          gap;
    int          oe_cyc;
    int          cs_exp;
    wdata  = $urandom;
    n_be   = lane_enables(addr, size);
    cs_exp = int'(tb_timing.f.cs_lead) + int'(tb_timing.f.wait_states) + 1;
    ahb_access(wr, addr, size, wdata, rdata, resp, first_resp, first_rdy,
               cycles, cs_cyc, stb_cyc, gap, n_we_seen, n_be_seen, addr_seen, oe_cyc);
    check_resp("smc_hresp", resp, OKAY);
    check_count("smc_n_cs low cycles", cs_cyc, cs_exp, 1'b0);
    check_count("strobe low cycles", stb_cyc, int'(tb_timing.f.wait_states) + 1, 1'b0);
    // Trail cycles plus the idle cycle that accepts
    check_count("smc_n_cs turnaround", gap, prev_trail + 1, 1'b1);
    check_word("smc_addr", addr_seen, addr);
    check_word("smc_n_be", {28'h0, n_be_seen}, {28'h0, n_be});
    check_count("smc_n_ext_oe low cycles", oe_cyc, wr ? cs_exp : 0, 1'b0);
    if (wr) begin
      check_word("smc_n_we", {28'h0, n_we_seen}, {28'h0, n_be});
      for (int i = 0; i < 4; i++) begin
        if (!n_be[i]) ref_mem[{addr[7:2], 2'(i)}] = wdata[8*i +: 8];
      end
    end else begin
      exp = {ref_mem[{addr[7:2], 2'd3}], ref_mem[{addr[7:2], 2'd2}],
             ref_mem[{addr[7:2], 2'd1}], ref_mem[{addr[7:2], 2'd0}]};
      check_word("smc_hrdata", rdata, exp);
    end
    prev_trail = int'(tb_timing.f.cs_trail);
  endtask

  //----------------------------------------------------------------------
  // Test sequence
  //----------------------------------------------------------------------
  initial begin
    logic [31:0] rd;
    logic [31:0] addr;
    logic [31:0] rdata;
    logic [3:0]  n_we_seen;
    logic [3:0]  n_be_seen;
    logic [31:0] addr_seen;
    smc_timing_u got;
    smc_timing_u exp;
    smc_resp_e   resp;
    smc_resp_e   first_resp;
    logic        first_rdy;
    int          cycles;
    int          cs_cyc;
    int          stb_cyc;
    int          gap;
    int          oe_cyc;
    void'($urandom(32'h4ff584d4));
    errors = 0;
    checks = 0;
    timeouts = 0;
    prev_trail = 0;
    {psel, penable, pwrite, paddr, pwdata} = '0;
    {haddr, htrans, hsel, hwrite, hsize, hwdata} = '0;
    hready = 1'b1;
    for (int i = 0; i < 256; i++) begin
      mem[i]     = 8'(i * 37 + 11);
      ref_mem[i] = 8'(i * 37 + 11);
    end
    rst_n = 1'b0;
    repeat (2) @(negedge hclk);
    rst_n = 1'b1;
    @(negedge hclk);

    // Reset values
    check_count("smc_hready", int'(smc_hready), 1, 1'b0);
    check_resp("smc_hresp", smc_resp_e'(smc_hresp), OKAY);
    check_word("EMI active-low outputs",
               {20'h0, smc_n_cs, smc_n_rd, smc_n_wr, smc_n_ext_oe, smc_n_we, smc_n_be},
               {20'h0, 12'hfff});
    check_count("smc_busy", int'(smc_busy), 0, 1'b0);
    apb_read(`SMC_REG_TIMING, rd);
    got.raw = rd;
    exp.raw = `SMC_TIMING_RESET;
    check_timing("prdata", got, exp);

    // Register write and readback, spare bits read zero
    repeat (6) begin
      rd = $urandom;
      apb_write(`SMC_REG_TIMING, rd);
      exp.raw = rd & 32'h0003_ff03;
      apb_read(`SMC_REG_TIMING, rd);
      got.raw = rd;
      check_timing("prdata", got, exp);
      apb_read(5'($urandom_range(1, 31)), rd);
      check_word("prdata other offset", rd, 32'h0);
    end

    // Data path and strobe timing under changing settings
    for (int n = 0; n < 60; n++) begin
      if (n % 8 == 0) begin
        tb_timing.raw           = '0;
        tb_timing.f.cs_lead     = 2'($urandom_range(0, 3));
        tb_timing.f.wait_states = 8'($urandom_range(0, 7));
        tb_timing.f.cs_trail    = 2'($urandom_range(0, 3));
        apb_write(`SMC_REG_TIMING, tb_timing.raw);
      end
      addr = $urandom_range(0, 255);
      case (n % 3)
        0:       legal_access(1'($urandom_range(0, 1)), addr, 3'd0);
        1:       legal_access(1'($urandom_range(0, 1)), {addr[31:1], 1'b0}, 3'd1);
        default: legal_access(1'($urandom_range(0, 1)), {addr[31:2], 2'b00}, 3'd2);
      endcase
    end

    // Misaligned halfwords and words
    repeat (4) begin
      addr = {24'h0, 6'($urandom_range(0, 63)), 2'b01};
      ahb_access(1'($urandom_range(0, 1)), addr, 3'($urandom_range(1, 2)), $urandom,
                 rdata, resp, first_resp, first_rdy, cycles, cs_cyc, stb_cyc, gap, n_we_seen,
                 n_be_seen, addr_seen, oe_cyc);
      check_count("smc_hready first error cycle", int'(first_rdy), 0, 1'b0);
      check_resp("smc_hresp first error cycle", first_resp, ERROR);
      check_resp("smc_hresp second error cycle", resp, ERROR);
      check_count("error response cycles", cycles, 2, 1'b0);
      check_count("smc_n_cs low on error", cs_cyc, 0, 1'b0);
    end

    repeat (4) @(negedge hclk);
    $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+common
common/smc_pkg.sv
common/smc_cmd_if.sv
rtl/smc_config_regs.sv
rtl/smc_ahb_slave.sv
emi/smc_emi_engine.sv
rtl/smc_top.sv
bench/smc_props.sv
bench/smc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and decide on the log contents
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f vlog.f --top-module smc_tb -o smc_sim &&
  { ./obj_dir/smc_sim > sim.log 2>&1 || true; } &&
  grep -qx "TB PASSED" sim.log &&
  echo "Simulation run ok, see sim.log" ||
  { echo "Simulation run failed, see sim.log"; exit 1; }
